//--- project.f
+incdir+verilog
verilog/rtc_pkg.sv
verilog/edge_sync.sv
verilog/rtc_counter.sv
verilog/event_capture.sv
verilog/rtc_regs.sv
verilog/rtc_top.sv
tests/rtc_tb.sv

//--- tests/rtc_tb.sv
// ------------------------------
// Testbench for the RTC subsystem
// Runs a table of register, pin and time steps against rtc_top
// Prints one line per step and the counts at the end
// ------------------------------
`timescale 1ns/1ps
`include "rtc_params.svh"

module rtc_tb
    import rtc_pkg::*;
();

    localparam logic [31:0] NS_STEP   = 32'(`RTC_NS_STEP);
    localparam logic [31:0] NS_MAX    = 32'(`RTC_NS_MAX);
    localparam int          SYNC      = `RTC_SYNC_STAGES;
    localparam int          SNAP_WAIT = 10;
    localparam int          MAX_STEPS = 48;

    // Step kinds
    localparam logic [2:0] OP_WR  = 3'd0;
    localparam logic [2:0] OP_RD  = 3'd1;
    localparam logic [2:0] OP_PIN = 3'd2;
    localparam logic [2:0] OP_SEC = 3'd3;
    localparam logic [2:0] OP_NS  = 3'd4;
    localparam logic [2:0] OP_PPS = 3'd5;

    // Pin select for OP_PIN
    localparam int PIN_PPS = 0;
    localparam int PIN_EVT = 1;

    typedef struct packed {
        logic [2:0]             op;
        logic [`RTC_ADDR_W-1:0] addr;
        logic [31:0]            data;
        logic [31:0]            expected;
        logic [15:0]            wait_cycles;
    } step_t;

    logic        clk;
    logic        rst;
    logic        reg_wr;
    logic        reg_rd;
    reg_addr_e   reg_addr;
    logic [31:0] reg_wdata;
    logic [31:0] reg_rdata;
    logic        pps_in;
    logic        evt_in;
    logic        pps_out;
    rtc_time_t   rtc_time;

    step_t       steps [0:MAX_STEPS-1];
    string       names [0:MAX_STEPS-1];
    int          n_steps = 0;
    int          checks_passed = 0;
    int          checks_failed = 0;
    int          pps_count = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    rtc_top i_rtc_top (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_addr  (reg_addr),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .pps_in    (pps_in),
        .evt_in    (evt_in),
        .pps_out   (pps_out),
        .rtc_time  (rtc_time)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Count cycles with pps_out high, sampled away from the rising edge
    always @(negedge clk) begin
        if (!rst && pps_out) begin
            pps_count++;
        end
    end

    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Run stopped after %0d cycles, the step table did not finish", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic add_step(input string name, input logic [2:0] op, input int addr,
                            input logic [31:0] data, input logic [31:0] expected,
                            input int wait_cycles);
        steps[n_steps] = '{op, addr[`RTC_ADDR_W-1:0], data, expected, wait_cycles[15:0]};
        names[n_steps] = name;
        n_steps++;
    endtask

    // Zero cycles takes no time, so steps stay 1 ns after an edge
    task automatic idle(input int cycles);
        if (cycles > 0) begin
            repeat (cycles) @(posedge clk);
            #1;
        end
    endtask

    // Every access starts 1 ns after an edge and ends 1 ns after the next
    task automatic write_reg(input logic [`RTC_ADDR_W-1:0] addr, input logic [31:0] data);
        reg_wr    = 1'b1;
        reg_addr  = reg_addr_e'(addr);
        reg_wdata = data;
        idle(1);
        reg_wr    = 1'b0;
    endtask

    task automatic read_reg(input logic [`RTC_ADDR_W-1:0] addr, output logic [31:0] data);
        reg_rd   = 1'b1;
        reg_addr = reg_addr_e'(addr);
        idle(1);
        reg_rd   = 1'b0;
        data     = reg_rdata;
    endtask

    task automatic pulse_pin(input int pin);
        if (pin == PIN_PPS) begin
            pps_in = 1'b1;
        end else begin
            evt_in = 1'b1;
        end
        idle(1);
        pps_in = 1'b0;
        evt_in = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) begin
            checks_passed++;
            $display("ok       %s", name);
        end else begin
            checks_failed++;
            $display("MISMATCH %s expected %0d actual %0d", name, expected, actual);
        end
    endtask

    task automatic run_step(input int idx);
        step_t       s;
        logic [31:0] value;
        s = steps[idx];
        case (s.op)
            OP_WR: begin
                write_reg(s.addr, s.data);
                $display("done     %s", names[idx]);
            end
            OP_RD: begin
                read_reg(s.addr, value);
                check_value(names[idx], s.expected, value);
            end
            OP_PIN: begin
                pulse_pin(s.addr);
                $display("done     %s", names[idx]);
            end
            OP_SEC: check_value(names[idx], s.expected, rtc_time.sec);
            OP_NS:  check_value(names[idx], s.expected, rtc_time.ns);
            OP_PPS: begin
                check_value(names[idx], s.expected, pps_count);
                pps_count = 0;
            end
            default: begin
                checks_failed++;
                $display("Step %s has an unknown kind %0d", names[idx], s.op);
            end
        endcase
        idle(s.wait_cycles);
    endtask

    task automatic build_table();
        // Reset values
        add_step("reset ctrl", OP_RD, CTRL, 0, 0, 0);
        add_step("reset stat sec", OP_RD, STAT_SEC, 0, 0, 0);
        add_step("reset evt status", OP_RD, EVT_STATUS, 0, 0, 0);
        add_step("reset no pps", OP_PPS, 0, 0, 0, 0);
        // Time set lands one cycle after the command pulse
        add_step("set sec 100", OP_WR, SET_SEC, 100, 0, 0);
        add_step("set ns 5000", OP_WR, SET_NS, 5000, 0, 0);
        add_step("cmd timeset", OP_WR, CMD, 1, 0, 1);
        add_step("loaded sec", OP_SEC, 0, 0, 100, 0);
        add_step("loaded ns", OP_NS, 0, 0, 5000, SNAP_WAIT);
        // Snapshot holds the time from the edge that raised timeget
        add_step("cmd timeget", OP_WR, CMD, 2, 0, 1);
        add_step("snapshot sec", OP_RD, STAT_SEC, 0, 100, 0);
        add_step("snapshot ns", OP_RD, STAT_NS, 0, 5000 + NS_STEP * (SNAP_WAIT + 1), 0);
        // Normal mode rollover, two steps before the end of a second
        add_step("no pps before rollover", OP_PPS, 0, 0, 0, 0);
        add_step("set sec 5", OP_WR, SET_SEC, 5, 0, 0);
        add_step("set ns near max", OP_WR, SET_NS, NS_MAX - 2 * NS_STEP, 0, 0);
        add_step("cmd timeset roll", OP_WR, CMD, 1, 0, 1 + 3);
        add_step("rollover sec", OP_SEC, 0, 0, 6, 0);
        add_step("rollover ns", OP_NS, 0, 0, 0, 3);
        add_step("rollover one pps", OP_PPS, 0, 0, 1, 0);
        // PPS mode counts past the normal rollover point
        add_step("ctrl pps mode", OP_WR, CTRL, 1, 0, 0);
        add_step("set sec 20", OP_WR, SET_SEC, 20, 0, 0);
        add_step("set ns max minus step", OP_WR, SET_NS, NS_MAX - NS_STEP, 0, 0);
        add_step("cmd timeset pps", OP_WR, CMD, 1, 0, 1 + 4);
        add_step("pps mode sec held", OP_SEC, 0, 0, 20, 0);
        add_step("pps mode ns past max", OP_NS, 0, 0, NS_MAX + 3 * NS_STEP, 0);
        add_step("pps mode no internal pps", OP_PPS, 0, 0, 0, 0);
        add_step("pulse pps pin", OP_PIN, PIN_PPS, 0, 0, SYNC + 1);
        add_step("pps pin sec", OP_SEC, 0, 0, 21, 0);
        add_step("pps pin ns", OP_NS, 0, 0, 0, 3);
        add_step("pps pin one pps", OP_PPS, 0, 0, 1, 0);
        // Event capture, overflow and status clear
        add_step("set sec 40", OP_WR, SET_SEC, 40, 0, 0);
        add_step("set ns 1000", OP_WR, SET_NS, 1000, 0, 0);
        add_step("cmd timeset evt", OP_WR, CMD, 1, 0, 1);
        add_step("pulse evt pin", OP_PIN, PIN_EVT, 0, 0, SYNC + 1);
        add_step("evt sec", OP_RD, EVT_SEC, 0, 40, 0);
        add_step("evt ns", OP_RD, EVT_NS, 0, 1000 + NS_STEP * (SYNC + 1), 0);
        add_step("pulse evt pin again", OP_PIN, PIN_EVT, 0, 0, SYNC + 1);
        add_step("evt ns kept", OP_RD, EVT_NS, 0, 1000 + NS_STEP * (SYNC + 1), 0);
        add_step("evt status overflow", OP_RD, EVT_STATUS, 0, 3, 1);
        add_step("evt status cleared", OP_RD, EVT_STATUS, 0, 0, 0);
    endtask

    initial begin
        int budget;
        rst       = 1'b1;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = CTRL;
        reg_wdata = '0;
        pps_in    = 1'b0;
        evt_in    = 1'b0;

        build_table();
        // Waits, one cycle per access and the reset, then a factor of two
        budget = 2;
        for (int i = 0; i < n_steps; i++) begin
            budget += steps[i].wait_cycles;
            if (steps[i].op == OP_WR || steps[i].op == OP_RD || steps[i].op == OP_PIN) begin
                budget += 1;
            end
        end
        cycle_limit = 2 * budget;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < n_steps; i++) begin
            run_step(i);
        end

        $display("Steps %0d, checks passed %0d, checks failed %0d",
                 n_steps, checks_passed, checks_failed);
        if (checks_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog/edge_sync.sv
// ------------------------------
// Pin synchronizer with rising-edge detect
// One instance per asynchronous input pin
// ------------------------------
`timescale 1ns/1ps
`include "rtc_params.svh"

module edge_sync #(
    parameter int STAGES = `RTC_SYNC_STAGES
) (
    input  logic clk,
    input  logic rst,
    input  logic async_in,
    output logic pulse
);

    logic [STAGES-1:0] sync_q;
    logic              hist_q;

    // Pulse rises STAGES + 1 edges after the pin goes high
    always_ff @(posedge clk) begin
        if (rst) begin
            sync_q <= '0;
            hist_q <= 1'b0;
            pulse  <= 1'b0;
        end else begin
            sync_q[0] <= async_in;
            for (int i = 1; i < STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
            hist_q <= sync_q[STAGES-1];
            pulse  <= sync_q[STAGES-1] & ~hist_q;
        end
    end

    // One pin edge gives exactly one cycle of pulse
    assert property (@(posedge clk) disable iff (rst) pulse |=> !pulse)
        else $error("edge_sync: pulse high for two cycles");

endmodule

//--- verilog/event_capture.sv
// ------------------------------
// Timestamps an external event
// First event latches the time, later ones set overflow
// Status read clears both flags
// ------------------------------
`timescale 1ns/1ps

module event_capture
    import rtc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      evt_pulse,
    input  logic      evt_clear,
    input  rtc_time_t rtc_time,
    output rtc_time_t evt_time,
    output logic      evt_valid,
    output logic      evt_overflow
);

    logic slot_busy;

    // A clear in the same cycle frees the slot for a new event
    assign slot_busy = evt_valid & ~evt_clear;

    always_ff @(posedge clk) begin
        if (rst) begin
            evt_time     <= '0;
            evt_valid    <= 1'b0;
            evt_overflow <= 1'b0;
        end else if (evt_pulse) begin
            if (slot_busy) begin
                // Keep the first timestamp
                evt_overflow <= 1'b1;
            end else begin
                evt_time     <= rtc_time;
                evt_valid    <= 1'b1;
                evt_overflow <= 1'b0;
            end
        end else if (evt_clear) begin
            evt_valid    <= 1'b0;
            evt_overflow <= 1'b0;
        end
    end

    // Overflow only makes sense on top of a held timestamp
    assert property (@(posedge clk) disable iff (rst) evt_overflow |-> evt_valid)
        else $error("event_capture: overflow without valid");

endmodule

//--- verilog/rtc_counter.sv
// ------------------------------
// Time-of-day counter, seconds and nanoseconds
// Normal mode rolls ns each second, PPS mode follows the pin
// Loads on timeset and snapshots on timeget
// ------------------------------
`timescale 1ns/1ps
`include "rtc_params.svh"

module rtc_counter
    import rtc_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rtc_ctrl_t rtc_ctrl,
    input  logic      pps_pulse,
    output rtc_time_t rtc_time,
    output rtc_time_t stat_time,
    output logic      pps_out
);

    localparam logic [31:0] NS_STEP = 32'(`RTC_NS_STEP);
    localparam logic [31:0] NS_MAX  = 32'(`RTC_NS_MAX);

    rtc_time_t time_d;
    logic      roll;

    // Second boundary source
    always_comb begin
        if (rtc_ctrl.pps_mode) begin
            roll = pps_pulse;
        end else begin
            roll = (rtc_time.ns >= NS_MAX);
        end
    end

    // Next time, set value wins over counting
    always_comb begin
        if (rtc_ctrl.timeset) begin
            time_d = rtc_ctrl.set_time;
        end else if (roll) begin
            time_d.sec = rtc_time.sec + 32'd1;
            time_d.ns  = '0;
        end else begin
            time_d.sec = rtc_time.sec;
            time_d.ns  = rtc_time.ns + NS_STEP;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rtc_time <= '0;
            pps_out  <= 1'b0;
        end else begin
            rtc_time <= time_d;
            // No PPS when software loads the time
            pps_out  <= roll & ~rtc_ctrl.timeset;
        end
    end

    // Snapshot holds the time from the previous edge
    always_ff @(posedge clk) begin
        if (rst) begin
            stat_time <= '0;
        end else if (rtc_ctrl.timeget) begin
            stat_time <= rtc_time;
        end
    end

    // In normal mode ns stays in range once a load or mode change has settled
    assert property (@(posedge clk) disable iff (rst)
        (!rtc_ctrl.pps_mode && !$past(rtc_ctrl.pps_mode) && !$past(rtc_ctrl.timeset))
        |-> (rtc_time.ns <= NS_MAX))
        else $error("rtc_counter: ns %0d beyond rollover point", rtc_time.ns);

endmodule

//--- verilog/rtc_params.svh
// ------------------------------
// Clock and register constants for the RTC subsystem
// Included by the package and by RTL that needs timing values
// ------------------------------
`ifndef RTC_PARAMS_SVH
`define RTC_PARAMS_SVH

// Core clock in Hz
`define RTC_CLK_FREQ_HZ 125000000

// Nanoseconds added per clock cycle
`define RTC_NS_STEP (1000000000 / `RTC_CLK_FREQ_HZ)

// Last ns value before the second rolls over
`define RTC_NS_MAX (1000000000 - `RTC_NS_STEP)

// Flops in each pin synchronizer
`define RTC_SYNC_STAGES 2

`define RTC_ADDR_W 4

`endif

//--- verilog/rtc_pkg.sv
// ------------------------------
// Shared types for the RTC subsystem
// Time of day, counter control and the register map
// ------------------------------
`include "rtc_params.svh"

package rtc_pkg;

    // Time of day as seconds and nanoseconds
    typedef struct packed {
        logic [31:0] sec;
        logic [31:0] ns;
    } rtc_time_t;

    // Register bank to counter
    typedef struct packed {
        logic      pps_mode;
        rtc_time_t set_time;
        logic      timeset;
        logic      timeget;
    } rtc_ctrl_t;

    // Register map
    typedef enum logic [`RTC_ADDR_W-1:0] {
        CTRL       = 0,
        SET_SEC    = 1,
        SET_NS     = 2,
        CMD        = 3,
        STAT_SEC   = 4,
        STAT_NS    = 5,
        EVT_SEC    = 6,
        EVT_NS     = 7,
        EVT_STATUS = 8
    } reg_addr_e;

endpackage

//--- verilog/rtc_regs.sv
// ------------------------------
// Register bank for the RTC
// Decodes write and read strobes into control and command pulses
// Read data is registered one cycle after the strobe
// ------------------------------
`timescale 1ns/1ps

module rtc_regs
    import rtc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_wr,
    input  logic        reg_rd,
    input  reg_addr_e   reg_addr,
    input  logic [31:0] reg_wdata,
    output logic [31:0] reg_rdata,
    input  rtc_time_t   stat_time,
    input  rtc_time_t   evt_time,
    input  logic        evt_valid,
    input  logic        evt_overflow,
    output rtc_ctrl_t   rtc_ctrl,
    output logic        evt_clear
);

    logic [31:0] rdata_d;

    // Mode, pending set time and command pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            rtc_ctrl <= '0;
        end else begin
            // Commands are single-cycle
            rtc_ctrl.timeset <= 1'b0;
            rtc_ctrl.timeget <= 1'b0;
            if (reg_wr) begin
                case (reg_addr)
                    CTRL: begin
                        rtc_ctrl.pps_mode <= reg_wdata[0];
                    end
                    SET_SEC: begin
                        rtc_ctrl.set_time.sec <= reg_wdata;
                    end
                    SET_NS: begin
                        rtc_ctrl.set_time.ns <= reg_wdata;
                    end
                    CMD: begin
                        rtc_ctrl.timeset <= reg_wdata[0];
                        rtc_ctrl.timeget <= reg_wdata[1];
                    end
                    default: begin
                        // Status and snapshot registers are read-only
                    end
                endcase
            end
        end
    end

    // Read multiplexer
    always_comb begin
        case (reg_addr)
            CTRL:       rdata_d = {31'd0, rtc_ctrl.pps_mode};
            SET_SEC:    rdata_d = rtc_ctrl.set_time.sec;
            SET_NS:     rdata_d = rtc_ctrl.set_time.ns;
            STAT_SEC:   rdata_d = stat_time.sec;
            STAT_NS:    rdata_d = stat_time.ns;
            EVT_SEC:    rdata_d = evt_time.sec;
            EVT_NS:     rdata_d = evt_time.ns;
            EVT_STATUS: rdata_d = {30'd0, evt_overflow, evt_valid};
            default:    rdata_d = '0;
        endcase
    end

    // Read data holds between reads
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_rd) begin
            reg_rdata <= rdata_d;
        end
    end

    // Status read clears the event flags on the following edge
    always_ff @(posedge clk) begin
        if (rst) begin
            evt_clear <= 1'b0;
        end else begin
            evt_clear <= reg_rd && (reg_addr == EVT_STATUS);
        end
    end

    // Host issues one access at a time
    assert property (@(posedge clk) disable iff (rst) !(reg_wr && reg_rd))
        else $error("rtc_regs: write and read strobes together");

endmodule

//--- verilog/rtc_top.sv
// ------------------------------
// Top level of the RTC subsystem
// Register bank, pin synchronizers, counter and event capture
// ------------------------------
`timescale 1ns/1ps

module rtc_top
    import rtc_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_wr,
    input  logic        reg_rd,
    input  reg_addr_e   reg_addr,
    input  logic [31:0] reg_wdata,
    output logic [31:0] reg_rdata,
    input  logic        pps_in,
    input  logic        evt_in,
    output logic        pps_out,
    output rtc_time_t   rtc_time
);

    rtc_ctrl_t rtc_ctrl;
    rtc_time_t stat_time;
    rtc_time_t evt_time;
    logic      pps_pulse;
    logic      evt_pulse;
    logic      evt_valid;
    logic      evt_overflow;
    logic      evt_clear;

    rtc_regs i_rtc_regs (
        .clk          (clk),
        .rst          (rst),
        .reg_wr       (reg_wr),
        .reg_rd       (reg_rd),
        .reg_addr     (reg_addr),
        .reg_wdata    (reg_wdata),
        .reg_rdata    (reg_rdata),
        .stat_time    (stat_time),
        .evt_time     (evt_time),
        .evt_valid    (evt_valid),
        .evt_overflow (evt_overflow),
        .rtc_ctrl     (rtc_ctrl),
        .evt_clear    (evt_clear)
    );

    edge_sync i_pps_sync (
        .clk      (clk),
        .rst      (rst),
        .async_in (pps_in),
        .pulse    (pps_pulse)
    );

    edge_sync i_evt_sync (
        .clk      (clk),
        .rst      (rst),
        .async_in (evt_in),
        .pulse    (evt_pulse)
    );

    rtc_counter i_rtc_counter (
        .clk       (clk),
        .rst       (rst),
        .rtc_ctrl  (rtc_ctrl),
        .pps_pulse (pps_pulse),
        .rtc_time  (rtc_time),
        .stat_time (stat_time),
        .pps_out   (pps_out)
    );

    event_capture i_event_capture (
        .clk          (clk),
        .rst          (rst),
        .evt_pulse    (evt_pulse),
        .evt_clear    (evt_clear),
        .rtc_time     (rtc_time),
        .evt_time     (evt_time),
        .evt_valid    (evt_valid),
        .evt_overflow (evt_overflow)
    );

endmodule
